// ==== rtl/imem_pkg.sv ====
// Instruction memory definitions
package imem_pkg;

    localparam int adr_w     = 12;          // Byte address bits, 4 KiB
    localparam int wrd_adr_w = adr_w - 2;   // Word address bits
    localparam int dat_w     = 32;          // Instruction word
    localparam int rom_wrds  = 1024;        // ROM depth in words
    localparam int rom_lat   = 2;           // ROM read latency

    // Register map
    typedef enum logic [1:0]
    {
        reg_ctrl   = 2'd0,                  // Bit 0 run pulse
        reg_start  = 2'd1,                  // Fetch start byte address
        reg_len    = 2'd2,                  // Fetch length in words
        reg_status = 2'd3                   // Busy, done and counts
    } reg_t;

    // Loader FSM
    typedef enum logic
    {
        ldr_idle = 1'b0,                    // Waiting for start word
        ldr_load = 1'b1                     // Word stream active
    } ldr_state_t;

    // Fetch FSM
    typedef enum logic [1:0]
    {
        fetch_idle  = 2'd0,                 // Waiting for run
        fetch_run   = 2'd1,                 // Issuing reads
        fetch_drain = 2'd2                  // Emptying queue
    } fetch_state_t;

endpackage

// ==== rtl/instr_rom.sv ====
// Instruction ROM
module instr_rom
(
    input  logic                             CLK_IN,     // Clock
    input  logic                             RST_IN,     // Reset
    input  logic                             init_wr,    // Init write strobe
    input  logic [imem_pkg::wrd_adr_w-1:0]   init_adr,   // Init word address
    input  logic [imem_pkg::dat_w-1:0]       init_dat,   // Init data
    input  logic                             rom_rd,     // Read request
    input  logic [imem_pkg::adr_w-1:0]       rom_adr,    // Read byte address
    output logic [imem_pkg::dat_w-1:0]       rom_dat,    // Read data
    output logic                             rom_vld     // Read data valid
);

    logic [imem_pkg::dat_w-1:0]     mem [imem_pkg::rom_wrds];  // Word array
    logic [imem_pkg::wrd_adr_w-1:0] port_adr;                  // Shared port address
    logic                           port_en;                   // Port enable
    logic [imem_pkg::wrd_adr_w-1:0] adr_q;                     // Address stage
    logic [imem_pkg::dat_w-1:0]     dat_q;                     // Output stage
    logic [imem_pkg::rom_lat-1:0]   vld_sr;                    // Valid pipeline

    // A write takes the port, read address drops byte offset
    assign port_adr = init_wr ? init_adr : rom_adr[imem_pkg::adr_w-1:2];
    assign port_en  = init_wr | rom_rd;                        // Like a BRAM enable

    // Memory, address and output registers
    always_ff @(posedge CLK_IN)
    begin
        if (init_wr)
            mem[port_adr] <= init_dat;                         // Init write
        if (port_en)
            adr_q <= port_adr;                                 // First stage
        if (vld_sr[0])
            dat_q <= mem[adr_q];                               // Second stage
    end

    // Two cycle valid pipeline
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            vld_sr <= '0;
        else
            vld_sr <= {vld_sr[0], rom_rd};                     // Shift in request
    end

    assign rom_dat = dat_q;
    assign rom_vld = vld_sr[imem_pkg::rom_lat-1];              // Last stage

    // Loader and fetch unit must never share the port
    a_no_collision : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !(init_wr && rom_rd))
        else $error("ROM write and read in the same cycle");

endmodule

// ==== rtl/rom_loader.sv ====
// ROM loader
module rom_loader
(
    input  logic                             CLK_IN,        // Clock
    input  logic                             RST_IN,        // Reset
    input  logic                             load_start,    // First word marker
    input  logic [imem_pkg::dat_w-1:0]       load_data,     // Load word
    input  logic                             load_valid,    // Load word valid
    input  logic                             fetch_busy,    // Fetch unit active
    output logic                             load_ready,    // Load word accepted
    output logic                             init_wr,       // ROM write strobe
    output logic [imem_pkg::wrd_adr_w-1:0]   init_adr,      // ROM word address
    output logic [imem_pkg::dat_w-1:0]       init_dat,      // ROM write data
    output logic                             loader_busy,   // Load in progress
    output logic [imem_pkg::wrd_adr_w:0]     loaded_count   // Words since start
);

    imem_pkg::ldr_state_t           state;      // Loader FSM
    logic                           rdy_en;     // High once out of reset
    logic                           accept;     // Handshake this cycle
    logic [imem_pkg::wrd_adr_w-1:0] ptr;        // Write pointer
    logic [imem_pkg::wrd_adr_w-1:0] wr_adr;     // Address for this word

    assign load_ready  = rdy_en & ~fetch_busy;               // No writes during fetch
    assign accept      = load_valid & load_ready;
    assign wr_adr      = load_start ? '0 : ptr;              // Start restarts at zero
    assign loader_busy = (state == imem_pkg::ldr_load) | init_wr;  // Covers last write

    // Control and counters
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            state        <= imem_pkg::ldr_idle;
            rdy_en       <= 1'b0;
            init_wr      <= 1'b0;
            ptr          <= '0;
            loaded_count <= '0;
        end
        else
        begin
            rdy_en  <= 1'b1;
            init_wr <= accept;                               // Write on next edge
            case (state)
                imem_pkg::ldr_idle :
                    if (accept && load_start)
                        state <= imem_pkg::ldr_load;
                default :
                    if (!load_valid)
                        state <= imem_pkg::ldr_idle;         // Stream gap ends load
            endcase
            if (accept)
            begin
                ptr          <= wr_adr + 1'b1;
                loaded_count <= (load_start ? '0 : loaded_count) + 1'b1;
            end
        end
    end

    // Write payload
    always_ff @(posedge CLK_IN)
    begin
        if (accept)
        begin
            init_adr <= wr_adr;
            init_dat <= load_data;
        end
    end

    a_no_wrap : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        accept && !load_start |-> loaded_count < imem_pkg::rom_wrds)
        else $error("Load overruns ROM size");

endmodule

// ==== rtl/fetch_regs.sv ====
// Fetch configuration registers
module fetch_regs
(
    input  logic                             CLK_IN,         // Clock
    input  logic                             RST_IN,         // Reset
    input  logic                             cfg_wr,         // Register write
    input  imem_pkg::reg_t                   cfg_adr,        // Register address
    input  logic [imem_pkg::dat_w-1:0]       cfg_wdata,      // Write data
    input  logic                             fetch_busy,     // Fetch active
    input  logic                             loader_busy,    // Load active
    input  logic                             done_pulse,     // Fetch finished
    input  logic [15:0]                      fetched_count,  // Words delivered
    input  logic [imem_pkg::wrd_adr_w:0]     loaded_count,   // Words loaded
    output logic [imem_pkg::dat_w-1:0]       cfg_rdata,      // Read data
    output logic [imem_pkg::adr_w-1:0]       start_adr,      // Fetch start
    output logic [15:0]                      fetch_len,      // Fetch length
    output logic                             run_pulse       // Start fetch
);

    logic done;     // Sticky done flag

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            start_adr <= '0;
            fetch_len <= '0;
            run_pulse <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            run_pulse <= 1'b0;                                   // Single cycle
            if (cfg_wr)
            begin
                case (cfg_adr)
                    imem_pkg::reg_ctrl  :
                        run_pulse <= cfg_wdata[0] & ~fetch_busy & ~loader_busy;
                    imem_pkg::reg_start : start_adr <= cfg_wdata[imem_pkg::adr_w-1:0];
                    imem_pkg::reg_len   : fetch_len <= cfg_wdata[15:0];
                    default             : ;                      // Status is read only
                endcase
            end
            if (run_pulse)
                done <= 1'b0;                                    // New run clears done
            else if (done_pulse)
                done <= 1'b1;
        end
    end

    // Read mux
    always_comb
    begin
        case (cfg_adr)
            imem_pkg::reg_start  : cfg_rdata = {20'd0, start_adr};
            imem_pkg::reg_len    : cfg_rdata = {16'd0, fetch_len};
            imem_pkg::reg_status :
                cfg_rdata = {fetched_count, loaded_count[7:0], 6'd0, done, fetch_busy};
            default              : cfg_rdata = '0;               // Ctrl is write only
        endcase
    end

endmodule

// ==== rtl/instr_fetch.sv ====
// Instruction fetch unit
module instr_fetch
#(
    parameter int q_depth = 4                                  // Output queue entries
)
(
    input  logic                             CLK_IN,           // Clock
    input  logic                             RST_IN,           // Reset
    input  logic                             run_pulse,        // Start fetch
    input  logic [imem_pkg::adr_w-1:0]       start_adr,        // Start byte address
    input  logic [15:0]                      fetch_len,        // Words to fetch
    input  logic [imem_pkg::dat_w-1:0]       rom_dat,          // ROM read data
    input  logic                             rom_vld,          // ROM data valid
    input  logic                             instr_ready,      // Consumer ready
    output logic                             fetch_busy,       // Fetch active
    output logic                             done_pulse,       // Last word delivered
    output logic [15:0]                      fetched_count,    // Words delivered
    output logic                             rom_rd,           // ROM read request
    output logic [imem_pkg::adr_w-1:0]       rom_adr,          // ROM byte address
    output logic                             instr_valid,      // Instruction valid
    output logic [imem_pkg::dat_w-1:0]       instr_data,       // Instruction word
    output logic [imem_pkg::adr_w-1:0]       instr_adr         // Instruction address
);

    imem_pkg::fetch_state_t            state;                       // Fetch FSM
    logic [imem_pkg::adr_w-1:0]        rd_adr;                      // Next read address
    logic [15:0]                       remaining;                   // Reads left to issue
    logic [imem_pkg::rom_lat-1:0]      pipe_vld;                    // Reads in flight
    logic [imem_pkg::adr_w-1:0]        pipe_adr [imem_pkg::rom_lat]; // Their addresses
    logic [imem_pkg::dat_w-1:0]        q_dat [q_depth];             // Queue data
    logic [imem_pkg::adr_w-1:0]        q_adr [q_depth];             // Queue addresses
    logic [$clog2(q_depth)-1:0]        wr_ptr;                      // Queue write slot
    logic [$clog2(q_depth)-1:0]        rd_ptr;                      // Queue read slot
    logic [$clog2(q_depth+1)-1:0]      count;                       // Queue occupancy
    logic                              pop;                         // Output handshake

    // Credit rule, queue plus in flight below depth
    assign rom_rd     = (state == imem_pkg::fetch_run) && (remaining != 0) &&
                        (count + $countones(pipe_vld) < q_depth);
    assign rom_adr    = rd_adr;
    assign fetch_busy = (state != imem_pkg::fetch_idle) | run_pulse;  // Blocks loader early
    assign done_pulse = (state == imem_pkg::fetch_drain) && (pipe_vld == '0) && (count == 0);

    assign instr_valid = (count != 0);
    assign instr_data  = q_dat[rd_ptr];                         // Held until popped
    assign instr_adr   = q_adr[rd_ptr];
    assign pop         = instr_valid & instr_ready;

    // FSM, issue and queue control
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            state         <= imem_pkg::fetch_idle;
            rd_adr        <= '0;
            remaining     <= '0;
            pipe_vld      <= '0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            fetched_count <= '0;
        end
        else
        begin
            pipe_vld <= {pipe_vld[imem_pkg::rom_lat-2:0], rom_rd};  // Tracks ROM latency
            case (state)
                imem_pkg::fetch_idle :
                    if (run_pulse)
                    begin
                        state         <= imem_pkg::fetch_run;
                        rd_adr        <= start_adr;
                        remaining     <= fetch_len;
                        fetched_count <= '0;
                    end
                imem_pkg::fetch_run :
                    if (remaining == 0 || (rom_rd && remaining == 1))
                        state <= imem_pkg::fetch_drain;     // All reads issued
                default :
                    if (done_pulse)
                        state <= imem_pkg::fetch_idle;
            endcase
            if (rom_rd)
            begin
                rd_adr    <= rd_adr + 3'd4;                 // Wraps at 4 KiB
                remaining <= remaining - 1'b1;
            end
            if (rom_vld)
                wr_ptr <= (wr_ptr == q_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
            begin
                rd_ptr        <= (rd_ptr == q_depth - 1) ? '0 : rd_ptr + 1'b1;
                fetched_count <= fetched_count + 1'b1;
            end
            if (rom_vld && !pop)
                count <= count + 1'b1;
            else if (!rom_vld && pop)
                count <= count - 1'b1;
        end
    end

    // Address pipeline and queue storage
    always_ff @(posedge CLK_IN)
    begin
        pipe_adr[0] <= rd_adr;
        for (int i = 1; i < imem_pkg::rom_lat; i++)
            pipe_adr[i] <= pipe_adr[i-1];                   // Aligns with rom_vld
        if (rom_vld)
        begin
            q_dat[wr_ptr] <= rom_dat;
            q_adr[wr_ptr] <= pipe_adr[imem_pkg::rom_lat-1];
        end
    end

    // Credit rule must hold against the ROM latency
    a_no_overflow : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        rom_vld |-> count < q_depth)
        else $error("ROM data arrived with queue full");

endmodule

// ==== rtl/instr_mem_top.sv ====
// Instruction memory top level
module instr_mem_top
(
    input  logic                             CLK_IN,        // Clock
    input  logic                             RST_IN,        // Reset
    input  logic                             load_start,    // First load word
    input  logic [imem_pkg::dat_w-1:0]       load_data,     // Load word
    input  logic                             load_valid,    // Load word valid
    output logic                             load_ready,    // Load word accepted
    input  logic                             cfg_wr,        // Register write
    input  imem_pkg::reg_t                   cfg_adr,       // Register address
    input  logic [imem_pkg::dat_w-1:0]       cfg_wdata,     // Register write data
    output logic [imem_pkg::dat_w-1:0]       cfg_rdata,     // Register read data
    input  logic                             instr_ready,   // Consumer ready
    output logic                             instr_valid,   // Instruction valid
    output logic [imem_pkg::dat_w-1:0]       instr_data,    // Instruction word
    output logic [imem_pkg::adr_w-1:0]       instr_adr      // Instruction address
);

    logic                           init_wr;        // Loader write strobe
    logic [imem_pkg::wrd_adr_w-1:0] init_adr;       // Loader word address
    logic [imem_pkg::dat_w-1:0]     init_dat;       // Loader data
    logic                           loader_busy;    // Load in progress
    logic [imem_pkg::wrd_adr_w:0]   loaded_count;   // Words loaded
    logic                           fetch_busy;     // Fetch in progress
    logic                           done_pulse;     // Fetch complete
    logic [15:0]                    fetched_count;  // Words delivered
    logic [imem_pkg::adr_w-1:0]     start_adr;      // Fetch start
    logic [15:0]                    fetch_len;      // Fetch length
    logic                           run_pulse;      // Fetch start strobe
    logic                           rom_rd;         // ROM read
    logic [imem_pkg::adr_w-1:0]     rom_adr;        // ROM byte address
    logic [imem_pkg::dat_w-1:0]     rom_dat;        // ROM data
    logic                           rom_vld;        // ROM data valid

    rom_loader rom_loader_i
    (
        .CLK_IN, .RST_IN, .load_start, .load_data, .load_valid, .fetch_busy,
        .load_ready, .init_wr, .init_adr, .init_dat, .loader_busy, .loaded_count
    );

    fetch_regs fetch_regs_i
    (
        .CLK_IN, .RST_IN, .cfg_wr, .cfg_adr, .cfg_wdata, .fetch_busy, .loader_busy,
        .done_pulse, .fetched_count, .loaded_count, .cfg_rdata, .start_adr,
        .fetch_len, .run_pulse
    );

    instr_fetch #(.q_depth(4)) instr_fetch_i
    (
        .CLK_IN, .RST_IN, .run_pulse, .start_adr, .fetch_len, .rom_dat, .rom_vld,
        .instr_ready, .fetch_busy, .done_pulse, .fetched_count, .rom_rd, .rom_adr,
        .instr_valid, .instr_data, .instr_adr
    );

    instr_rom instr_rom_i
    (
        .CLK_IN, .RST_IN, .init_wr, .init_adr, .init_dat, .rom_rd, .rom_adr,
        .rom_dat, .rom_vld
    );

endmodule

// ==== sim/tb_instr_mem.sv ====
// Instruction memory testbench
module tb_instr_mem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half     = 50;                   // 100 ns clock
    localparam int tq       = 25;                   // Sample point after falling edge
    localparam int max_cmds = 64;

    logic           CLK_IN;
    logic           RST_IN;
    logic           load_start;
    logic [31:0]    load_data;
    logic           load_valid;
    logic           load_ready;
    logic           cfg_wr;
    imem_pkg::reg_t cfg_adr;
    logic [31:0]    cfg_wdata;
    logic [31:0]    cfg_rdata;
    logic           instr_ready;
    logic           instr_valid;
    logic [31:0]    instr_data;
    logic [11:0]    instr_adr;

    logic [7:0]  cmd_c [max_cmds];                  // Command letter
    logic        cmd_s [max_cmds];                  // Load line starts at zero
    int          cmd_a [max_cmds];                  // Register or byte address
    logic [31:0] cmd_v [max_cmds];                  // Data or expected value
    int          cmd_n [max_cmds];                  // Word count or ready mode
    int          n_cmd = 0;
    int          limit_cycles = 0;                  // Watchdog budget
    logic [31:0] image [imem_pkg::rom_wrds];        // Reference ROM image
    int          model_ptr = 0;                     // Reference write pointer
    logic [31:0] seen_dat [$];                      // Delivered words
    logic [11:0] seen_adr [$];
    logic        hold = 1'b0;                       // Stalled word last cycle
    logic [31:0] hold_dat;
    logic [11:0] hold_adr;
    logic        random_ready = 1'b0;
    logic [31:0] rnd = 32'h2e00_1c96;
    int          checks = 0;
    int          errors = 0;

    instr_mem_top instr_mem_top_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic read_patterns();
        int          fd;
        int          code;
        int          words;
        int          a;
        int          n;
        logic [31:0] v;
        logic [63:0] tok;
        logic [63:0] flag;
        logic [1023:0] rest;
        words = 0;
        fd = $fopen("sim/instr_mem_patterns.txt", "r");
        checks++;
        assert (fd != 0)
        else
        begin
            errors++;
            $display("Could not open the pattern file sim/instr_mem_patterns.txt");
        end
        if (fd != 0)
        begin
            while (n_cmd < max_cmds && $fscanf(fd, "%s", tok) == 1)
            begin
                if (tok == "#")
                    code = $fgets(rest, fd);                // Comment line
                else
                begin
                    a = 0;
                    n = 0;
                    v = '0;
                    flag = '0;
                    if (tok == "L")
                        code = $fscanf(fd, "%s %h %d", flag, v, n);
                    else if (tok == "B")
                        code = $fscanf(fd, "%d", n);
                    else
                        code = $fscanf(fd, "%h %h", a, v);  // W, R and E lines
                    checks++;
                    assert (code == ((tok == "L") ? 3 : (tok == "B") ? 1 : 2))
                    else
                    begin
                        errors++;
                        $display("Pattern entry %0d has missing fields", n_cmd);
                    end
                    cmd_c[n_cmd] = tok[7:0];
                    cmd_s[n_cmd] = (flag == "S");
                    cmd_a[n_cmd] = a;
                    cmd_v[n_cmd] = v;
                    cmd_n[n_cmd] = n;
                    if (tok == "L")
                        words += n;
                    n_cmd++;
                end
            end
            $fclose(fd);
        end
        limit_cycles = 200 * n_cmd + words + 50;            // One cycle per loaded word
    endtask

    task automatic load_words(input int i);
        logic [31:0] dat;
        for (int k = 0; k < cmd_n[i]; k++)
        begin
            @(negedge CLK_IN);
            dat        = cmd_v[i] + k;                      // Fill follows word address
            load_valid = 1'b1;
            load_start = cmd_s[i] && (k == 0);
            load_data  = dat;
            #(tq);
            while (!load_ready)
            begin
                @(negedge CLK_IN);
                #(tq);
            end
            if (load_start)
                model_ptr = 0;                              // Start word restarts image
            image[model_ptr] = dat;
            model_ptr = (model_ptr + 1) % imem_pkg::rom_wrds;
        end
        @(negedge CLK_IN);
        load_valid = 1'b0;
        load_start = 1'b0;
    endtask

    task automatic write_reg(input int i);
        logic [31:0] want;
        @(negedge CLK_IN);
        cfg_wr    = 1'b1;
        cfg_adr   = imem_pkg::reg_t'(cmd_a[i][1:0]);
        cfg_wdata = cmd_v[i];
        @(negedge CLK_IN);
        cfg_wr    = 1'b0;                               // Single write
        if (cmd_a[i] == 1 || cmd_a[i] == 2)
        begin
            // Start holds 12 address bits, length 16 bits
            want = (cmd_a[i] == 1) ? (cmd_v[i] & 32'h0000_0fff) : (cmd_v[i] & 32'h0000_ffff);
            #(tq);
            checks++;
            assert (cfg_rdata === want)
            else
            begin
                errors++;
                $display("error %0t: register %0d reads back %h, expected %h", $time,
                         cmd_a[i], cfg_rdata, want);
            end
        end
    endtask

    task automatic read_reg(input int i);
        logic [31:0] got;
        int          tries;
        tries = 0;
        @(negedge CLK_IN);
        cfg_adr = imem_pkg::reg_t'(cmd_a[i][1:0]);
        #(tq);
        got = cfg_rdata;
        while (got !== cmd_v[i] && tries < 16)          // Done trails last handshake
        begin
            @(negedge CLK_IN);
            #(tq);
            got = cfg_rdata;
            tries++;
        end
        checks++;
        assert (got === cmd_v[i])
        else
        begin
            errors++;
            $display("error %0t: register %0d read %h, expected %h", $time, cmd_a[i], got,
                     cmd_v[i]);
        end
    endtask

    task automatic expect_word(input int i);
        logic [31:0] dat;
        logic [11:0] adr;
        while (seen_dat.size() == 0)
            @(negedge CLK_IN);
        dat = seen_dat.pop_front();
        adr = seen_adr.pop_front();
        checks += 2;
        assert (image[cmd_a[i][11:2]] === cmd_v[i])
        else
        begin
            errors++;
            $display("error %0t: pattern word %h at %h differs from loaded %h", $time,
                     cmd_v[i], cmd_a[i][11:0], image[cmd_a[i][11:2]]);
        end
        assert (adr === cmd_a[i][11:0] && dat === cmd_v[i])
        else
        begin
            errors++;
            $display("error %0t: got %h at %h, expected %h at %h", $time, dat, adr,
                     cmd_v[i], cmd_a[i][11:0]);
        end
    endtask

    task automatic run_command(input int i);
        case (cmd_c[i])
            "L" : load_words(i);
            "W" : write_reg(i);
            "R" : read_reg(i);
            "E" : expect_word(i);
            "B" : random_ready = (cmd_n[i] != 0);        // Applies from next falling edge
            default :
            begin
                errors++;
                $display("Unknown pattern command %c at entry %0d", cmd_c[i], i);
            end
        endcase
    endtask

    initial
    begin
        CLK_IN = 1'b0;
        forever #(half) CLK_IN = ~CLK_IN;
    end

    // Consumer ready is random while a B 1 line is active
    initial
    begin
        instr_ready = 1'b1;
        forever
        begin
            @(negedge CLK_IN);
            rnd = xorshift(rnd);
            instr_ready = random_ready ? rnd[7] : 1'b1;
        end
    end

    // Output monitor samples in the low phase before the handshake edge
    initial
    begin
        forever
        begin
            @(negedge CLK_IN);
            #(tq);
            if (hold)
            begin
                checks++;
                assert (instr_valid && instr_data === hold_dat && instr_adr === hold_adr)
                else
                begin
                    errors++;
                    $display("error %0t: output changed while stalled", $time);
                end
            end
            checks++;
            assert (!(instr_valid && load_ready))
            else
            begin
                errors++;
                $display("error %0t: load stream ready while an instruction was pending",
                         $time);
            end
            if (instr_valid && instr_ready)
            begin
                seen_dat.push_back(instr_data);
                seen_adr.push_back(instr_adr);
            end
            hold     = instr_valid && !instr_ready;
            hold_dat = instr_data;
            hold_adr = instr_adr;
        end
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge CLK_IN);
        $display("Watchdog expired after %0d cycles before the tests finished", limit_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        RST_IN     = 1'b1;
        load_start = 1'b0;
        load_data  = '0;
        load_valid = 1'b0;
        cfg_wr     = 1'b0;
        cfg_adr    = imem_pkg::reg_status;
        cfg_wdata  = '0;
        read_patterns();
        repeat (5) @(negedge CLK_IN);
        RST_IN = 1'b0;
        for (int i = 0; i < n_cmd; i++)
            run_command(i);
        repeat (20) @(negedge CLK_IN);                  // Catch words from an ignored run
        checks++;
        assert (seen_dat.size() == 0)
        else
        begin
            errors++;
            $display("%0d extra instruction words were delivered", seen_dat.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/imem_pkg.sv
rtl/instr_rom.sv
rtl/rom_loader.sv
rtl/fetch_regs.sv
rtl/instr_fetch.sv
rtl/instr_mem_top.sv
sim/tb_instr_mem.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP   = tb_instr_mem
LIST  = all.f
LOG   = sim.log
FAIL  = Done: errors found
PASS  = Done: no errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/instr_mem_patterns.txt ====
# L start(S or -) first word(hex) count, word k of the line is first + k
# W/R register(0 ctrl 1 start 2 len 3 status) value(hex), E address word(hex), B ready mode
L S 10000013 1024
B 0
W 1 00000000
W 2 00000004
W 0 00000001
R 3 00000001
E 000 10000013
E 004 10000014
E 008 10000015
E 00c 10000016
R 3 00040002
W 1 00000ff8
W 2 00000004
W 0 00000001
E ff8 10000411
E ffc 10000412
E 000 10000013
E 004 10000014
R 3 00040002
B 1
W 1 00000000
W 2 00000005
W 0 00000001
W 0 00000001
E 000 10000013
E 004 10000014
E 008 10000015
E 00c 10000016
E 010 10000017
R 3 00050002
B 0
L S a5000000 3
W 1 00000000
W 2 00000003
W 0 00000001
E 000 a5000000
E 004 a5000001
E 008 a5000002
R 3 00030302
